//--- rtl/cdc_pkg.sv
`default_nettype none

package cdc_pkg;

    // Flops per synchronizer chain
    localparam int sync_depth = 2;

    // Crossing cells in the FIFO ring, also the FIFO depth
    localparam int fifo_stages = 5;

    // Ring index, counts 0 .. fifo_stages-1
    typedef logic [$clog2(fifo_stages)-1:0] ring_ptr_t;

endpackage

`default_nettype wire

//--- rtl/cmd_pkg.sv
`default_nettype none

package cmd_pkg;

    localparam int data_w    = 16;
    localparam int reg_count = 8;

    typedef logic [$clog2(reg_count)-1:0] addr_t;
    typedef logic [data_w-1:0]            data_t;

    typedef enum logic [1:0] {
        op_write = 2'd0,
        op_read  = 2'd1,
        op_add   = 2'd2,
        op_xor   = 2'd3
    } op_e;

    ////////////////////////////////////////////////////////////////////
    // Host command, one FIFO word
    typedef struct packed {
        op_e   op;
        addr_t addr;
        data_t data;
    } cmd_t;

    localparam int cmd_w = $bits(cmd_t);

    // Decode to execute
    typedef struct packed {
        logic  valid;
        logic  wr_en;   // Entry gets written back
        op_e   op;
        addr_t addr;
        data_t data;
    } dec_t;

    typedef struct packed {
        logic  valid;
        addr_t addr;
        data_t data;    // Entry value after the command
    } rsp_t;

endpackage

`default_nettype wire

//--- rtl/level_sync.sv
`timescale 1ns/10ps
`default_nettype none

module level_sync (
     input  logic clk
    ,input  logic rst_n
    ,input  logic din
    ,output logic dout
);

    import cdc_pkg::*;

    logic [sync_depth-1:0] chain;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            chain <= '0;
        end else begin
            chain <= {chain[sync_depth-2:0], din};
        end
    end

    assign dout = chain[sync_depth-1];   // Last flop of the chain

endmodule

`default_nettype wire

//--- rtl/async_stage.sv
`timescale 1ns/10ps
`default_nettype none

module async_stage #(
    parameter int WID = 32
) (
     input  logic           wclk
    ,input  logic           rst_nw
    ,input  logic           writex
    ,input  logic [WID-1:0] wdata
    ,output logic           wfull

    ,input  logic           rclk
    ,input  logic           rst_nr
    ,input  logic           readx
    ,output logic [WID-1:0] rdata
    ,output logic           rempty
);

    logic           wflag;      // Flips once per write
    logic           rflag;      // Flips once per read
    logic           rflag_w;    // rflag seen in wclk domain
    logic           wflag_r;    // wflag seen in rclk domain
    logic [WID-1:0] store;

    ////////////////////////////////////////////////////////////////////
    // Write side

    always_ff @(posedge wclk or negedge rst_nw) begin
        if (!rst_nw) begin
            wflag <= 1'b0;
        end else if (writex) begin
            wflag <= ~wflag;
        end
    end

    always_ff @(posedge wclk) begin
        if (writex) begin
            store <= wdata;
        end
    end

    level_sync u_rflag_sync (.clk(wclk), .rst_n(rst_nw), .din(rflag), .dout(rflag_w));

    // Occupied until the read toggle comes back
    assign wfull = wflag ^ rflag_w;

    ////////////////////////////////////////////////////////////////////
    // Read side

    always_ff @(posedge rclk or negedge rst_nr) begin
        if (!rst_nr) begin
            rflag <= 1'b0;
        end else if (readx) begin
            rflag <= ~rflag;
        end
    end

    level_sync u_wflag_sync (.clk(rclk), .rst_n(rst_nr), .din(wflag), .dout(wflag_r));

    assign rempty = (rflag == wflag_r);
    assign rdata  = store;   // Stable while not empty

endmodule

`default_nettype wire

//--- rtl/async5fifo.sv
`timescale 1ns/10ps
`default_nettype none

module async5fifo #(
    parameter int WID = 32
) (
     input  logic           rst_nr
    ,input  logic           wclk
    ,input  logic           writex
    ,input  logic [WID-1:0] wdata
    ,output logic           wfull

    ,input  logic           rclk
    ,input  logic           readx
    ,output logic [WID-1:0] rdata
    ,output logic           rempty

    ,output logic           rst_nr_sync
    ,output logic           rst_nw_sync
);

    import cdc_pkg::*;

    localparam ring_ptr_t last_ptr = ring_ptr_t'(fifo_stages - 1);

    logic [fifo_stages-1:0] stage_wfull;
    logic [fifo_stages-1:0] stage_rempty;
    logic [fifo_stages-1:0] stage_writex;
    logic [fifo_stages-1:0] stage_readx;
    logic [WID-1:0]         stage_rdata [fifo_stages];

    ring_ptr_t wptr;
    ring_ptr_t rptr;

    // Reset release, synchronized per domain
    level_sync u_rst_r (.clk(rclk), .rst_n(rst_nr), .din(1'b1), .dout(rst_nr_sync));
    level_sync u_rst_w (.clk(wclk), .rst_n(rst_nr), .din(1'b1), .dout(rst_nw_sync));

    ////////////////////////////////////////////////////////////////////
    // Ring pointers, each local to its own clock

    always_ff @(posedge wclk or negedge rst_nw_sync) begin
        if (!rst_nw_sync) begin
            wptr <= '0;
        end else if (writex && !wfull) begin
            wptr <= (wptr == last_ptr) ? '0 : wptr + 1'b1;
        end
    end

    always_ff @(posedge rclk or negedge rst_nr_sync) begin
        if (!rst_nr_sync) begin
            rptr <= '0;
        end else if (readx && !rempty) begin
            rptr <= (rptr == last_ptr) ? '0 : rptr + 1'b1;
        end
    end

    assign wfull  = stage_wfull[wptr];    // Next slot still occupied
    assign rempty = stage_rempty[rptr];
    assign rdata  = stage_rdata[rptr];

    ////////////////////////////////////////////////////////////////////
    // Stage ring

    for (genvar i = 0; i < fifo_stages; i++) begin : g_stage
        assign stage_writex[i] = writex && !stage_wfull[i] && (wptr == ring_ptr_t'(i));
        assign stage_readx[i]  = readx && !stage_rempty[i] && (rptr == ring_ptr_t'(i));

        async_stage #(.WID(WID)) u_stage (
             .wclk   (wclk)
            ,.rst_nw (rst_nw_sync)
            ,.writex (stage_writex[i])
            ,.wdata  (wdata)
            ,.wfull  (stage_wfull[i])
            ,.rclk   (rclk)
            ,.rst_nr (rst_nr_sync)
            ,.readx  (stage_readx[i])
            ,.rdata  (stage_rdata[i])
            ,.rempty (stage_rempty[i])
        );
    end

endmodule

`default_nettype wire

//--- rtl/cmd_decode.sv
`timescale 1ns/10ps
`default_nettype none

module cmd_decode (
     input  logic          rclk
    ,input  logic          rst_nr
    ,input  cmd_pkg::cmd_t rdata
    ,input  logic          rempty
    ,output logic          readx
    ,output cmd_pkg::dec_t dec
);

    import cmd_pkg::*;

    logic valid_q;
    logic wr_en_q;
    cmd_t cmd_q;

    // Never stalls
    assign readx = ~rempty;

    always_ff @(posedge rclk or negedge rst_nr) begin
        if (!rst_nr) begin
            valid_q <= 1'b0;
            wr_en_q <= 1'b0;
        end else begin
            valid_q <= readx;
            wr_en_q <= readx && (rdata.op != op_read);   // Read leaves entry alone
        end
    end

    always_ff @(posedge rclk) begin
        if (readx) begin
            cmd_q <= rdata;
        end
    end

    assign dec = '{
        valid: valid_q,
        wr_en: wr_en_q,
        op:    cmd_q.op,
        addr:  cmd_q.addr,
        data:  cmd_q.data
    };

endmodule

`default_nettype wire

//--- rtl/reg_execute.sv
`timescale 1ns/10ps
`default_nettype none

module reg_execute (
     input  logic          rclk
    ,input  logic          rst_nr
    ,input  cmd_pkg::dec_t dec
    ,output cmd_pkg::rsp_t rsp
);

    import cmd_pkg::*;

    data_t regs [reg_count];
    data_t old_val;
    data_t new_val;
    logic  rsp_valid;
    addr_t rsp_addr;
    data_t rsp_data;

    assign old_val = regs[dec.addr];

    always_comb begin
        new_val = old_val;
        case (dec.op)
            op_write: new_val = dec.data;
            op_read:  new_val = old_val;
            op_add:   new_val = old_val + dec.data;   // Wraps mod 2^16
            op_xor:   new_val = old_val ^ dec.data;
            default:  new_val = old_val;
        endcase
    end

    ////////////////////////////////////////////////////////////////////
    // Register file, cleared on reset

    always_ff @(posedge rclk or negedge rst_nr) begin
        if (!rst_nr) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (dec.valid && dec.wr_en) begin
            regs[dec.addr] <= new_val;
        end
    end

    always_ff @(posedge rclk or negedge rst_nr) begin
        if (!rst_nr) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= dec.valid;   // One pulse per command
        end
    end

    always_ff @(posedge rclk) begin
        if (dec.valid) begin
            rsp_addr <= dec.addr;
            rsp_data <= new_val;
        end
    end

    assign rsp = '{valid: rsp_valid, addr: rsp_addr, data: rsp_data};

endmodule

`default_nettype wire

//--- rtl/cmd_bridge.sv
`timescale 1ns/10ps
`default_nettype none

module cmd_bridge (
     input  logic          rst_nr
    ,input  logic          wclk
    ,input  logic          rclk
    ,input  logic          writex
    ,input  cmd_pkg::cmd_t cmd
    ,output logic          wfull
    ,output cmd_pkg::rsp_t rsp
);

    import cmd_pkg::*;

    cmd_t fifo_rdata;
    logic fifo_rempty;
    logic fifo_readx;
    logic rst_nr_sync;
    dec_t dec;

    ////////////////////////////////////////////////////////////////////
    // wclk to rclk crossing

    async5fifo #(.WID(cmd_w)) u_fifo (
         .rst_nr      (rst_nr)
        ,.wclk        (wclk)
        ,.writex      (writex)
        ,.wdata       (cmd)
        ,.wfull       (wfull)
        ,.rclk        (rclk)
        ,.readx       (fifo_readx)
        ,.rdata       (fifo_rdata)
        ,.rempty      (fifo_rempty)
        ,.rst_nr_sync (rst_nr_sync)
        ,.rst_nw_sync ()             // Used inside the FIFO only
    );

    ////////////////////////////////////////////////////////////////////
    // rclk side pipeline

    cmd_decode u_decode (
         .rclk   (rclk)
        ,.rst_nr (rst_nr_sync)
        ,.rdata  (fifo_rdata)
        ,.rempty (fifo_rempty)
        ,.readx  (fifo_readx)
        ,.dec    (dec)
    );

    reg_execute u_execute (
         .rclk   (rclk)
        ,.rst_nr (rst_nr_sync)
        ,.dec    (dec)
        ,.rsp    (rsp)
    );

endmodule

`default_nettype wire

//--- tests/cmd_bridge_tb.sv
`timescale 1ns/10ps
`default_nettype none

module cmd_bridge_tb;

    import cdc_pkg::*;
    import cmd_pkg::*;

    localparam int n_directed     = 10;
    localparam int n_burst        = fifo_stages + 10;
    localparam int n_random       = 400;
    localparam int n_cmds         = n_directed + n_burst + n_random;
    localparam int timeout_cycles = n_cmds * (sync_depth + 4) + 200;   // In rclk cycles

    logic  rclk;
    logic  wclk;
    logic  rst_nr;
    logic  writex;
    cmd_t  cmd;
    logic  wfull;
    rsp_t  rsp;

    data_t       model_regs [reg_count];
    rsp_t        exp_q [$];
    logic [15:0] lfsr_state;
    logic        saw_full;

    cmd_bridge UUT (
         .rst_nr (rst_nr)
        ,.wclk   (wclk)
        ,.rclk   (rclk)
        ,.writex (writex)
        ,.cmd    (cmd)
        ,.wfull  (wfull)
        ,.rsp    (rsp)
    );

    initial begin
        rclk = 1'b0;
        forever #50 rclk = ~rclk;
    end

    initial begin
        wclk = 1'b0;
        forever #35 wclk = ~wclk;   // Unrelated to rclk
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Applies a command to the model array and returns the new entry value
    function automatic data_t model_apply(input cmd_t c);
        data_t old_v;
        data_t new_v;
        old_v = model_regs[c.addr];
        case (c.op)
            op_write: new_v = c.data;
            op_add:   new_v = old_v + c.data;
            op_xor:   new_v = old_v ^ c.data;
            default:  new_v = old_v;   // Read
        endcase
        model_regs[c.addr] = new_v;
        return new_v;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] want,
                               input string what);
        if (got !== want) begin
            $display("Mismatch at time %0t: %s is %0h, expected %0h", $time, what, got, want);
            $display("sim failed");
            $fatal(1, "Stopping at first error");
        end
    endtask

    task automatic idle_cycles(input int n);
        writex = 1'b0;
        repeat (n) begin
            @(posedge wclk);
            #5;
        end
    endtask

    // Entered and left 5 ns after a wclk edge
    task automatic send_cmd(input op_e op, input addr_t addr, input data_t data);
        cmd_t c;
        rsp_t e;
        logic full_at_edge;
        logic accepted;
        c.op     = op;
        c.addr   = addr;
        c.data   = data;
        cmd      = c;
        writex   = 1'b1;
        accepted = 1'b0;
        while (!accepted) begin
            full_at_edge = wfull;   // Settled since the last wclk edge
            @(posedge wclk);
            #5;
            if (full_at_edge) begin
                saw_full = 1'b1;
            end else begin
                accepted = 1'b1;
            end
        end
        writex = 1'b0;
        e.valid = 1'b1;
        e.addr  = addr;
        e.data  = model_apply(c);
        exp_q.push_back(e);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Response compare at mid cycle

    always @(negedge rclk) begin : compare
        rsp_t want;
        if (rsp.valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("Response at time %0t with no command outstanding", $time);
                $display("sim failed");
                $fatal(1, "Unexpected response");
            end else begin
                want = exp_q.pop_front();
                check_value(32'(rsp.addr), 32'(want.addr), "response address");
                check_value(32'(rsp.data), 32'(want.data), "response data");
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < timeout_cycles) begin
            @(posedge rclk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d rclk cycles", timeout_cycles);
        $display("sim failed");
        $fatal(1, "Timeout");
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus

    initial begin : stimulus
        op_e   r_op;
        addr_t r_addr;
        data_t r_data;
        int    gap;
        writex     = 1'b0;
        cmd        = '0;
        rst_nr     = 1'b0;
        lfsr_state = 16'd25851;
        saw_full   = 1'b0;
        for (int i = 0; i < reg_count; i++) begin
            model_regs[i] = '0;
        end

        repeat (10) @(posedge rclk);
        #5 rst_nr = 1'b1;
        idle_cycles(10);                     // Synchronized resets let go
        check_value(32'(wfull), 32'd0, "wfull after reset");

        // Write and read back, then read a never written entry
        send_cmd(op_write, 3'd3, 16'hA5C3);
        idle_cycles(2);
        send_cmd(op_read, 3'd3, 16'h0000);
        send_cmd(op_read, 3'd5, 16'h0000);
        idle_cycles(2);

        // add and xor with a read back after each
        send_cmd(op_add, 3'd3, 16'h1234);
        send_cmd(op_read, 3'd3, 16'h0000);
        send_cmd(op_xor, 3'd3, 16'h0FF0);
        send_cmd(op_read, 3'd3, 16'h0000);
        send_cmd(op_write, 3'd6, 16'hFFF0);
        send_cmd(op_add, 3'd6, 16'h0025);    // Wraps past 2^16
        send_cmd(op_read, 3'd6, 16'h0000);
        idle_cycles(4);

        // Back-to-back burst to fill the ring
        saw_full = 1'b0;
        for (int i = 0; i < n_burst; i++) begin
            r_data = data_t'(rand_bits(16));
            send_cmd(op_write, addr_t'(i), r_data);
        end
        check_value(32'(saw_full), 32'd1, "wfull seen during burst");

        for (int n = 0; n < n_random; n++) begin
            gap = int'(rand_bits(2));
            if (gap != 0) begin
                idle_cycles(gap);
            end
            r_op   = op_e'(rand_bits(2));
            r_addr = addr_t'(rand_bits(3));
            r_data = data_t'(rand_bits(16));
            send_cmd(r_op, r_addr, r_data);
        end

        writex = 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge rclk);
        end
        repeat (20) @(posedge rclk);          // Catch late extra responses
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- cmd_bridge.f
rtl/cdc_pkg.sv
rtl/cmd_pkg.sv
rtl/level_sync.sv
rtl/async_stage.sv
rtl/async5fifo.sv
rtl/cmd_decode.sv
rtl/reg_execute.sv
rtl/cmd_bridge.sv
tests/cmd_bridge_tb.sv

//--- Bender.yml
package:
  name: cmd_bridge

sources:
  # Packages first, then RTL bottom up
  - rtl/cdc_pkg.sv
  - rtl/cmd_pkg.sv
  - rtl/level_sync.sv
  - rtl/async_stage.sv
  - rtl/async5fifo.sv
  - rtl/cmd_decode.sv
  - rtl/reg_execute.sv
  - rtl/cmd_bridge.sv
  - target: test
    files:
      - tests/cmd_bridge_tb.sv
